// File: Makefile
TOP := mem_subsystem_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --timescale 1ns/100ps -f verilog.f --top-module $(TOP)

# the run is started from the project root so the vector file path resolves
sim:
	verilator --binary --timing --timescale 1ns/100ps -f verilog.f --top-module $(TOP) \
		--Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir

// File: design/axi_arbiter.sv
`timescale 1ns/100ps

module axi_arbiter (
    input  logic                              clk,
    input  logic                              rst,

    input  logic                              ifu_arvalid,
    output logic                              ifu_arready,
    input  logic [axi_mem_pkg::ADDR_W-1:0]    ifu_araddr,
    input  logic [axi_mem_pkg::ID_W-1:0]      ifu_arid,
    output logic                              ifu_rvalid,
    input  logic                              ifu_rready,
    output logic [axi_mem_pkg::DATA_W-1:0]    ifu_rdata,
    output logic [1:0]                        ifu_rresp,
    output logic [axi_mem_pkg::ID_W-1:0]      ifu_rid,

    input  logic                              lsu_arvalid,
    output logic                              lsu_arready,
    input  logic [axi_mem_pkg::ADDR_W-1:0]    lsu_araddr,
    input  logic [axi_mem_pkg::ID_W-1:0]      lsu_arid,
    output logic                              lsu_rvalid,
    input  logic                              lsu_rready,
    output logic [axi_mem_pkg::DATA_W-1:0]    lsu_rdata,
    output logic [1:0]                        lsu_rresp,
    output logic [axi_mem_pkg::ID_W-1:0]      lsu_rid,
    input  logic                              lsu_awvalid,
    output logic                              lsu_awready,
    input  logic [axi_mem_pkg::ADDR_W-1:0]    lsu_awaddr,
    input  logic [axi_mem_pkg::ID_W-1:0]      lsu_awid,
    input  logic                              lsu_wvalid,
    output logic                              lsu_wready,
    input  logic [axi_mem_pkg::DATA_W-1:0]    lsu_wdata,
    input  logic [axi_mem_pkg::STRB_W-1:0]    lsu_wstrb,
    output logic                              lsu_bvalid,
    input  logic                              lsu_bready,
    output logic [1:0]                        lsu_bresp,
    output logic [axi_mem_pkg::ID_W-1:0]      lsu_bid,

    output logic                              s_arvalid,
    input  logic                              s_arready,
    output logic [axi_mem_pkg::ADDR_W-1:0]    s_araddr,
    output logic [axi_mem_pkg::ID_W-1:0]      s_arid,
    input  logic                              s_rvalid,
    output logic                              s_rready,
    input  logic [axi_mem_pkg::DATA_W-1:0]    s_rdata,
    input  logic [1:0]                        s_rresp,
    input  logic [axi_mem_pkg::ID_W-1:0]      s_rid,
    output logic                              s_awvalid,
    input  logic                              s_awready,
    output logic [axi_mem_pkg::ADDR_W-1:0]    s_awaddr,
    output logic [axi_mem_pkg::ID_W-1:0]      s_awid,
    output logic                              s_wvalid,
    input  logic                              s_wready,
    output logic [axi_mem_pkg::DATA_W-1:0]    s_wdata,
    output logic [axi_mem_pkg::STRB_W-1:0]    s_wstrb,
    input  logic                              s_bvalid,
    output logic                              s_bready,
    input  logic [1:0]                        s_bresp,
    input  logic [axi_mem_pkg::ID_W-1:0]      s_bid
);

    typedef enum logic [1:0] {
        OWN_IFU_RD = 2'd0,
        OWN_LSU_RD = 2'd1,
        OWN_LSU_WR = 2'd2,
        OWN_NONE   = 2'd3
    } owner_t;

    owner_t                                   owner;
    owner_t                                   pick;
    owner_t                                   sel;
    logic [1:0]                               rr;        // last winner
    logic [2:0]                               req;
    logic [axi_mem_pkg::ID_W-1:0]             saved_id;
    logic                                     resp_done;

    assign req = {lsu_awvalid & lsu_wvalid, lsu_arvalid, ifu_arvalid};

    // ####################################################################
    // round-robin choice, starting after the last winner
    // ####################################################################
    always_comb begin
        int idx;
        pick = OWN_NONE;
        for (int k = 3; k >= 1; k--) begin
            idx = (int'(rr) + k) % 3;
            if (req[idx]) begin
                pick = owner_t'(idx[1:0]);               // nearest candidate is assigned last
            end
        end
    end

    assign sel       = (owner == OWN_NONE) ? pick : owner;
    assign resp_done = (s_rvalid & s_rready) | (s_bvalid & s_bready);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            owner <= OWN_NONE;
            rr    <= 2'd2;                               // ifu goes first after reset
        end else if (owner != OWN_NONE) begin
            if (resp_done) begin
                owner <= OWN_NONE;
            end
        end else if (pick != OWN_NONE) begin             // slave is idle, so it takes the request now
            owner <= pick;
            rr    <= pick;
        end
    end

    always_ff @(posedge clk) begin
        if (owner == OWN_NONE) begin
            case (pick)
                OWN_IFU_RD: saved_id <= ifu_arid;
                OWN_LSU_RD: saved_id <= lsu_arid;
                OWN_LSU_WR: saved_id <= lsu_awid;
                default:    saved_id <= saved_id;
            endcase
        end
    end

    // ####################################################################
    // request forwarding
    // ####################################################################
    assign s_arvalid   = ((sel == OWN_IFU_RD) & ifu_arvalid) | ((sel == OWN_LSU_RD) & lsu_arvalid);
    assign s_araddr    = (sel == OWN_LSU_RD) ? lsu_araddr : ifu_araddr;
    assign s_arid      = (sel == OWN_LSU_RD) ? axi_mem_pkg::SRC_LSU : axi_mem_pkg::SRC_IFU;
    assign ifu_arready = (sel == OWN_IFU_RD) & s_arready;
    assign lsu_arready = (sel == OWN_LSU_RD) & s_arready;

    assign s_awvalid   = (sel == OWN_LSU_WR) & lsu_awvalid;
    assign s_wvalid    = (sel == OWN_LSU_WR) & lsu_wvalid;
    assign s_awaddr    = lsu_awaddr;
    assign s_awid      = axi_mem_pkg::SRC_LSU;
    assign s_wdata     = lsu_wdata;
    assign s_wstrb     = lsu_wstrb;
    assign lsu_awready = (sel == OWN_LSU_WR) & s_awready;
    assign lsu_wready  = (sel == OWN_LSU_WR) & s_wready;

    // ####################################################################
    // response routing by echoed id
    // ####################################################################
    assign ifu_rvalid = s_rvalid & (s_rid == axi_mem_pkg::SRC_IFU);
    assign lsu_rvalid = s_rvalid & (s_rid == axi_mem_pkg::SRC_LSU);
    assign s_rready   = (s_rid == axi_mem_pkg::SRC_IFU) ? ifu_rready : lsu_rready;
    assign ifu_rdata  = s_rdata;
    assign lsu_rdata  = s_rdata;
    assign ifu_rresp  = s_rresp;
    assign lsu_rresp  = s_rresp;
    assign ifu_rid    = saved_id;                        // master sees its own id again
    assign lsu_rid    = saved_id;

    assign lsu_bvalid = s_bvalid & (s_bid == axi_mem_pkg::SRC_LSU);
    assign s_bready   = lsu_bready;
    assign lsu_bresp  = s_bresp;
    assign lsu_bid    = saved_id;

endmodule

// File: design/axi_mem_pkg.sv
package axi_mem_pkg;

    localparam int ADDR_W    = 32;
    localparam int DATA_W    = 32;
    localparam int STRB_W    = DATA_W / 8;
    localparam int ID_W      = 4;

    localparam int MEM_WORDS = 1024;
    localparam int IDX_W     = $clog2(MEM_WORDS);  // word index bits, byte offset excluded

    // ####################################################################
    // response codes
    // ####################################################################
    localparam logic [1:0] RESP_OKAY   = 2'd0;
    localparam logic [1:0] RESP_SLVERR = 2'd2;

    // ####################################################################
    // ids the arbiter puts on the slave side to tag the owner
    // ####################################################################
    localparam logic [ID_W-1:0] SRC_IFU = ID_W'(0);
    localparam logic [ID_W-1:0] SRC_LSU = ID_W'(1);

endpackage

// File: design/axi_sram.sv
`timescale 1ns/100ps

module axi_sram (
    input  logic                              clk,
    input  logic                              rst,

    input  logic                              arvalid,
    output logic                              arready,
    input  logic [axi_mem_pkg::ADDR_W-1:0]    araddr,
    input  logic [axi_mem_pkg::ID_W-1:0]      arid,

    output logic                              rvalid,
    input  logic                              rready,
    output logic [axi_mem_pkg::DATA_W-1:0]    rdata,
    output logic [1:0]                        rresp,
    output logic [axi_mem_pkg::ID_W-1:0]      rid,

    input  logic                              awvalid,
    output logic                              awready,
    input  logic [axi_mem_pkg::ADDR_W-1:0]    awaddr,
    input  logic [axi_mem_pkg::ID_W-1:0]      awid,

    input  logic                              wvalid,
    output logic                              wready,
    input  logic [axi_mem_pkg::DATA_W-1:0]    wdata,
    input  logic [axi_mem_pkg::STRB_W-1:0]    wstrb,

    output logic                              bvalid,
    input  logic                              bready,
    output logic [1:0]                        bresp,
    output logic [axi_mem_pkg::ID_W-1:0]      bid
);

    typedef enum logic {
        IDLE,
        BUSY
    } state_t;

    state_t                                   state;
    logic                                     op_wr;     // set when the busy transaction is a write
    logic                                     wr_done;   // write data taken, response due next cycle
    logic [axi_mem_pkg::ADDR_W-1:0]           addr_q;
    logic [axi_mem_pkg::IDX_W-1:0]            idx;
    logic                                     in_range;
    logic                                     w_fire;

    logic [axi_mem_pkg::DATA_W-1:0]           mem [axi_mem_pkg::MEM_WORDS];

    assign arready  = (state == IDLE);
    assign w_fire   = awvalid & awready & wvalid & wready;
    assign idx      = addr_q[axi_mem_pkg::IDX_W+1:2];
    // all address bits above the word index must be zero
    assign in_range = (addr_q[axi_mem_pkg::ADDR_W-1:axi_mem_pkg::IDX_W+2] == '0);

    // ####################################################################
    // control FSM
    // ####################################################################
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= IDLE;
            op_wr   <= 1'b0;
            awready <= 1'b0;
            wready  <= 1'b0;
            wr_done <= 1'b0;
            rvalid  <= 1'b0;
            bvalid  <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (arvalid) begin                   // reads win over writes
                        state <= BUSY;
                        op_wr <= 1'b0;
                    end else if (awvalid && wvalid) begin
                        state   <= BUSY;
                        op_wr   <= 1'b1;
                        awready <= 1'b1;
                        wready  <= 1'b1;
                    end
                end
                BUSY: begin
                    if (!op_wr) begin
                        if (!rvalid) begin
                            rvalid <= 1'b1;
                        end else if (rready) begin
                            rvalid <= 1'b0;
                            state  <= IDLE;
                        end
                    end else begin
                        if (awready) begin               // ready is up for one cycle only
                            awready <= 1'b0;
                            wready  <= 1'b0;
                            wr_done <= 1'b1;
                        end
                        if (wr_done) begin
                            wr_done <= 1'b0;
                            bvalid  <= 1'b1;
                        end
                        if (bvalid && bready) begin
                            bvalid <= 1'b0;
                            state  <= IDLE;
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // ####################################################################
    // address, id and response payload
    // ####################################################################
    always_ff @(posedge clk) begin
        if (state == IDLE) begin
            if (arvalid) begin
                addr_q <= araddr;
                rid    <= arid;
            end else if (awvalid && wvalid) begin
                addr_q <= awaddr;
                bid    <= awid;
            end
        end
        if (state == BUSY && !op_wr && !rvalid) begin
            rdata <= in_range ? mem[idx] : '0;
            rresp <= in_range ? axi_mem_pkg::RESP_OKAY : axi_mem_pkg::RESP_SLVERR;
        end
        if (awready) begin
            bresp <= in_range ? axi_mem_pkg::RESP_OKAY : axi_mem_pkg::RESP_SLVERR;
        end
    end

    // byte lanes are merged into the stored word, out of range writes are dropped
    always_ff @(posedge clk) begin
        if (w_fire && in_range) begin
            for (int i = 0; i < axi_mem_pkg::STRB_W; i++) begin
                if (wstrb[i]) begin
                    mem[idx][8*i +: 8] <= wdata[8*i +: 8];
                end
            end
        end
    end

endmodule

// File: design/mem_subsystem.sv
`timescale 1ns/100ps

module mem_subsystem (
    input  logic                              clk,
    input  logic                              rst,

    input  logic                              ifu_arvalid,
    output logic                              ifu_arready,
    input  logic [axi_mem_pkg::ADDR_W-1:0]    ifu_araddr,
    input  logic [axi_mem_pkg::ID_W-1:0]      ifu_arid,
    output logic                              ifu_rvalid,
    input  logic                              ifu_rready,
    output logic [axi_mem_pkg::DATA_W-1:0]    ifu_rdata,
    output logic [1:0]                        ifu_rresp,
    output logic [axi_mem_pkg::ID_W-1:0]      ifu_rid,

    input  logic                              lsu_arvalid,
    output logic                              lsu_arready,
    input  logic [axi_mem_pkg::ADDR_W-1:0]    lsu_araddr,
    input  logic [axi_mem_pkg::ID_W-1:0]      lsu_arid,
    output logic                              lsu_rvalid,
    input  logic                              lsu_rready,
    output logic [axi_mem_pkg::DATA_W-1:0]    lsu_rdata,
    output logic [1:0]                        lsu_rresp,
    output logic [axi_mem_pkg::ID_W-1:0]      lsu_rid,
    input  logic                              lsu_awvalid,
    output logic                              lsu_awready,
    input  logic [axi_mem_pkg::ADDR_W-1:0]    lsu_awaddr,
    input  logic [axi_mem_pkg::ID_W-1:0]      lsu_awid,
    input  logic                              lsu_wvalid,
    output logic                              lsu_wready,
    input  logic [axi_mem_pkg::DATA_W-1:0]    lsu_wdata,
    input  logic [axi_mem_pkg::STRB_W-1:0]    lsu_wstrb,
    output logic                              lsu_bvalid,
    input  logic                              lsu_bready,
    output logic [1:0]                        lsu_bresp,
    output logic [axi_mem_pkg::ID_W-1:0]      lsu_bid
);

    // slave side of the arbiter, owner id in place of the master id
    logic                                     s_arvalid;
    logic                                     s_arready;
    logic [axi_mem_pkg::ADDR_W-1:0]           s_araddr;
    logic [axi_mem_pkg::ID_W-1:0]             s_arid;
    logic                                     s_rvalid;
    logic                                     s_rready;
    logic [axi_mem_pkg::DATA_W-1:0]           s_rdata;
    logic [1:0]                               s_rresp;
    logic [axi_mem_pkg::ID_W-1:0]             s_rid;
    logic                                     s_awvalid;
    logic                                     s_awready;
    logic [axi_mem_pkg::ADDR_W-1:0]           s_awaddr;
    logic [axi_mem_pkg::ID_W-1:0]             s_awid;
    logic                                     s_wvalid;
    logic                                     s_wready;
    logic [axi_mem_pkg::DATA_W-1:0]           s_wdata;
    logic [axi_mem_pkg::STRB_W-1:0]           s_wstrb;
    logic                                     s_bvalid;
    logic                                     s_bready;
    logic [1:0]                               s_bresp;
    logic [axi_mem_pkg::ID_W-1:0]             s_bid;

    // port names of the arbiter match the names here one to one
    axi_arbiter u_arbiter (.*);

    axi_sram u_sram (
        .clk     (clk),
        .rst     (rst),
        .arvalid (s_arvalid),
        .arready (s_arready),
        .araddr  (s_araddr),
        .arid    (s_arid),
        .rvalid  (s_rvalid),
        .rready  (s_rready),
        .rdata   (s_rdata),
        .rresp   (s_rresp),
        .rid     (s_rid),
        .awvalid (s_awvalid),
        .awready (s_awready),
        .awaddr  (s_awaddr),
        .awid    (s_awid),
        .wvalid  (s_wvalid),
        .wready  (s_wready),
        .wdata   (s_wdata),
        .wstrb   (s_wstrb),
        .bvalid  (s_bvalid),
        .bready  (s_bready),
        .bresp   (s_bresp),
        .bid     (s_bid)
    );

endmodule

// File: tests/mem_subsystem_tb.sv
`timescale 1ns/100ps

module mem_subsystem_tb;

    // every field of a vector line is read as a 32-bit hex number
    typedef struct packed {
        logic [31:0] ifu_en;
        logic [31:0] ifu_addr;
        logic [31:0] ifu_id;
        logic [31:0] ifu_resp;
        logic [31:0] ifu_data;
        logic [31:0] lsu_op;
        logic [31:0] lsu_addr;
        logic [31:0] lsu_id;
        logic [31:0] lsu_wdata;
        logic [31:0] lsu_wstrb;
        logic [31:0] lsu_resp;
        logic [31:0] lsu_rdata;
    } vec_t;

    logic                              clk;
    logic                              rst;
    logic                              ifu_arvalid;
    logic                              ifu_arready;
    logic [axi_mem_pkg::ADDR_W-1:0]    ifu_araddr;
    logic [axi_mem_pkg::ID_W-1:0]      ifu_arid;
    logic                              ifu_rvalid;
    logic                              ifu_rready;
    logic [axi_mem_pkg::DATA_W-1:0]    ifu_rdata;
    logic [1:0]                        ifu_rresp;
    logic [axi_mem_pkg::ID_W-1:0]      ifu_rid;
    logic                              lsu_arvalid;
    logic                              lsu_arready;
    logic [axi_mem_pkg::ADDR_W-1:0]    lsu_araddr;
    logic [axi_mem_pkg::ID_W-1:0]      lsu_arid;
    logic                              lsu_rvalid;
    logic                              lsu_rready;
    logic [axi_mem_pkg::DATA_W-1:0]    lsu_rdata;
    logic [1:0]                        lsu_rresp;
    logic [axi_mem_pkg::ID_W-1:0]      lsu_rid;
    logic                              lsu_awvalid;
    logic                              lsu_awready;
    logic [axi_mem_pkg::ADDR_W-1:0]    lsu_awaddr;
    logic [axi_mem_pkg::ID_W-1:0]      lsu_awid;
    logic                              lsu_wvalid;
    logic                              lsu_wready;
    logic [axi_mem_pkg::DATA_W-1:0]    lsu_wdata;
    logic [axi_mem_pkg::STRB_W-1:0]    lsu_wstrb;
    logic                              lsu_bvalid;
    logic                              lsu_bready;
    logic [1:0]                        lsu_bresp;
    logic [axi_mem_pkg::ID_W-1:0]      lsu_bid;

    vec_t                              vecs [$];
    bit                                loaded = 1'b0;

    mem_subsystem dut (.*);

    always #20 clk = ~clk;                               // 40 ns period

    // ####################################################################
    // checking
    // ####################################################################
    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        if (actual !== expected) begin
            $display("error at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
            $display("Finished with errors");
            $fatal(1, "response mismatch");
        end
    endtask

    task automatic next_sample;
        @(negedge clk);
        #10;                                             // a quarter period after the drive
    endtask

    task automatic ifu_r_check(input vec_t v);
        check("ifu_rvalid", 32'(ifu_rvalid), 32'd1);
        check("ifu_rdata", ifu_rdata, v.ifu_data);
        check("ifu_rresp", 32'(ifu_rresp), v.ifu_resp);
        check("ifu_rid", 32'(ifu_rid), v.ifu_id);
    endtask

    task automatic lsu_r_check(input vec_t v);
        check("lsu_rvalid", 32'(lsu_rvalid), 32'd1);
        check("lsu_rdata", lsu_rdata, v.lsu_rdata);
        check("lsu_rresp", 32'(lsu_rresp), v.lsu_resp);
        check("lsu_rid", 32'(lsu_rid), v.lsu_id);
    endtask

    task automatic lsu_b_check(input vec_t v);
        check("lsu_bvalid", 32'(lsu_bvalid), 32'd1);
        check("lsu_bresp", 32'(lsu_bresp), v.lsu_resp);
        check("lsu_bid", 32'(lsu_bid), v.lsu_id);
    endtask

    // ####################################################################
    // master side transactions
    // ####################################################################
    task automatic ifu_read(input vec_t v);
        int stall;
        @(negedge clk);
        ifu_arvalid = 1'b1;
        ifu_araddr  = v.ifu_addr;
        ifu_arid    = v.ifu_id[axi_mem_pkg::ID_W-1:0];
        #10;
        while (!ifu_arready) next_sample();
        @(negedge clk);
        ifu_arvalid = 1'b0;
        #10;
        while (!ifu_rvalid) next_sample();
        stall = $urandom % 6;                            // extra cycles with rready low
        repeat (stall) begin
            ifu_r_check(v);
            next_sample();
        end
        ifu_r_check(v);
        @(negedge clk);
        ifu_rready = 1'b1;
        #10;
        ifu_r_check(v);
        @(negedge clk);
        ifu_rready = 1'b0;
    endtask

    task automatic lsu_read(input vec_t v);
        int stall;
        @(negedge clk);
        lsu_arvalid = 1'b1;
        lsu_araddr  = v.lsu_addr;
        lsu_arid    = v.lsu_id[axi_mem_pkg::ID_W-1:0];
        #10;
        while (!lsu_arready) next_sample();
        @(negedge clk);
        lsu_arvalid = 1'b0;
        #10;
        while (!lsu_rvalid) next_sample();
        stall = $urandom % 6;
        repeat (stall) begin
            lsu_r_check(v);
            next_sample();
        end
        lsu_r_check(v);
        @(negedge clk);
        lsu_rready = 1'b1;
        #10;
        lsu_r_check(v);
        @(negedge clk);
        lsu_rready = 1'b0;
    endtask

    task automatic lsu_write(input vec_t v);
        int stall;
        @(negedge clk);
        lsu_awvalid = 1'b1;
        lsu_awaddr  = v.lsu_addr;
        lsu_awid    = v.lsu_id[axi_mem_pkg::ID_W-1:0];
        lsu_wvalid  = 1'b1;
        lsu_wdata   = v.lsu_wdata;
        lsu_wstrb   = v.lsu_wstrb[axi_mem_pkg::STRB_W-1:0];
        #10;
        while (!(lsu_awready && lsu_wready)) next_sample();  // address and data go together
        @(negedge clk);
        lsu_awvalid = 1'b0;
        lsu_wvalid  = 1'b0;
        #10;
        while (!lsu_bvalid) next_sample();
        stall = $urandom % 6;
        repeat (stall) begin
            lsu_b_check(v);
            next_sample();
        end
        lsu_b_check(v);
        @(negedge clk);
        lsu_bready = 1'b1;
        #10;
        lsu_b_check(v);
        @(negedge clk);
        lsu_bready = 1'b0;
    endtask

    // both masters run side by side and each waits for its own grant
    task automatic run_vector(input vec_t v);
        fork
            begin
                if (v.ifu_en != 0) ifu_read(v);
            end
            begin
                if (v.lsu_op == 1) lsu_read(v);
                else if (v.lsu_op == 2) lsu_write(v);
            end
        join
    endtask

    // ####################################################################
    // main sequence
    // ####################################################################
    initial begin
        int    fd;
        string line;
        vec_t  v;
        void'($urandom(32'hadbc_41a6));
        clk         = 1'b0;
        rst         = 1'b1;
        ifu_arvalid = 1'b0;
        ifu_araddr  = '0;
        ifu_arid    = '0;
        ifu_rready  = 1'b0;
        lsu_arvalid = 1'b0;
        lsu_araddr  = '0;
        lsu_arid    = '0;
        lsu_rready  = 1'b0;
        lsu_awvalid = 1'b0;
        lsu_awaddr  = '0;
        lsu_awid    = '0;
        lsu_wvalid  = 1'b0;
        lsu_wdata   = '0;
        lsu_wstrb   = '0;
        lsu_bready  = 1'b0;

        fd = $fopen("tests/mem_subsystem_vectors.txt", "r");
        if (fd == 0) begin
            $display("could not open tests/mem_subsystem_vectors.txt");
            $display("Finished with errors");
            $fatal(1, "missing vector file");
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if ($sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h",
                        v.ifu_en, v.ifu_addr, v.ifu_id, v.ifu_resp, v.ifu_data,
                        v.lsu_op, v.lsu_addr, v.lsu_id, v.lsu_wdata, v.lsu_wstrb,
                        v.lsu_resp, v.lsu_rdata) == 12) begin
                vecs.push_back(v);                       // comment lines do not parse
            end
        end
        $fclose(fd);
        if (vecs.size() == 0) begin
            $display("the vector file holds no transactions");
            $display("Finished with errors");
            $fatal(1, "empty vector file");
        end
        loaded = 1'b1;

        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        #10;
        check("ifu_rvalid", 32'(ifu_rvalid), 32'd0);
        check("lsu_rvalid", 32'(lsu_rvalid), 32'd0);
        check("lsu_bvalid", 32'(lsu_bvalid), 32'd0);
        check("lsu_awready", 32'(lsu_awready), 32'd0);
        check("lsu_wready", 32'(lsu_wready), 32'd0);
        check("ifu_arready", 32'(ifu_arready), 32'd0);   // no request, so no grant holder
        check("lsu_arready", 32'(lsu_arready), 32'd0);

        foreach (vecs[i]) begin
            run_vector(vecs[i]);
        end
        $display("Finished with no errors");
        $finish;
    end

    // 30 cycles per vector line plus the reset phase
    initial begin
        wait (loaded);
        #(vecs.size() * 30 * 40 + 400);
        $display("timeout: the transactions did not complete in the allowed time");
        $display("Finished with errors");
        $fatal(1, "watchdog expired");
    end

endmodule

// File: tests/mem_subsystem_vectors.txt
# ifu columns: en addr id exp_resp exp_data, then lsu columns: op addr id wdata wstrb exp_resp exp_rdata
# lsu op 0 is idle, 1 read, 2 write; resp 0 is okay, 2 slave error; all fields hex
0 00000000 0 0 00000000  2 00000010 3 deadbeef f 0 00000000
1 00000010 5 0 deadbeef  0 00000000 0 00000000 0 0 00000000
0 00000000 0 0 00000000  1 00000010 a 00000000 0 0 deadbeef
0 00000000 0 0 00000000  2 00000000 4 cafef00d f 0 00000000
0 00000000 0 0 00000000  2 00000020 1 12345678 f 0 00000000
0 00000000 0 0 00000000  2 00000020 2 aabbccdd 5 0 00000000
0 00000000 0 0 00000000  1 00000020 2 00000000 0 0 12bb56dd
0 00000000 0 0 00000000  2 00000020 7 99887766 a 0 00000000
1 00000020 1 0 99bb77dd  1 00000010 4 00000000 0 0 deadbeef
0 00000000 0 0 00000000  2 00000010 9 ffffffff 0 0 00000000
1 00000010 d 0 deadbeef  1 00000000 c 00000000 0 0 cafef00d
0 00000000 0 0 00000000  2 00001000 6 11111111 f 2 00000000
1 00001000 c 2 00000000  1 00001000 9 00000000 0 2 00000000
1 00000000 b 0 cafef00d  2 00000030 b 0badc0de f 0 00000000
1 00000030 3 0 0badc0de  1 00000020 8 00000000 0 0 99bb77dd
0 00000000 0 0 00000000  2 00000030 e 000000ff 1 0 00000000
1 00000030 2 0 0badc0ff  1 fffffffc 5 00000000 0 2 00000000
0 00000000 0 0 00000000  2 00000ffc f 5a5aa5a5 f 0 00000000
1 00000ffc 0 0 5a5aa5a5  1 00000020 1 00000000 0 0 99bb77dd
1 00002000 7 2 00000000  2 00002000 3 ffffffff 3 2 00000000
1 00000000 6 0 cafef00d  1 00000010 5 00000000 0 0 deadbeef
0 00000000 0 0 00000000  2 00000040 0 01020304 f 0 00000000
0 00000000 0 0 00000000  2 00000040 1 a0b0c0d0 6 0 00000000
1 00000010 e 0 deadbeef  1 00000040 c 00000000 0 0 01b0c004
0 00000000 0 0 00000000  2 00000040 2 77000000 8 0 00000000
1 00000040 f 0 77b0c004  1 00000ffc 3 00000000 0 0 5a5aa5a5

// File: verilog.f
design/axi_mem_pkg.sv
design/axi_sram.sv
design/axi_arbiter.sv
design/mem_subsystem.sv
tests/mem_subsystem_tb.sv
